// File: build.f
+incdir+hdl
hdl/mem_pkg.sv
hdl/boot_pkg.sv
hdl/word_ram.sv
hdl/cpu_datamem.sv
hdl/cpu_boot.sv
hdl/cpu.sv
testbench/tb_cpu.sv

// File: hdl/boot_pkg.sv
// host and boot types
package boot_pkg;

    // host bus operation
    typedef enum logic [1:0] {
        IDLE  = 2'b00,
        READ  = 2'b01,
        WRITE = 2'b11     // encoding only, never driven here
    } bus_op_t;

    // boot sequencer states
    typedef enum logic [2:0] {
        BOOT_IDLE,        // waiting for host ready
        WAIT_DM,          // request out for a data segment
        LOAD_DM,          // streaming data words
        WAIT_IM,          // request out for an instruction segment
        LOAD_IM,          // streaming instruction words
        RUN               // memories loaded
    } boot_state_t;

    // address as seen by the host
    typedef logic [63:0] host_addr_t;

endpackage

// File: hdl/cpu.sv
// cpu boot and memory top
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu (
    input  logic                 clk,
    input  logic                 rst_n,
    // host
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  mem_pkg::data_word_t  ex_wrt_data,
    output boot_pkg::bus_op_t    op,
    output boot_pkg::host_addr_t ex_addr,
    // accelerator
    input  mem_pkg::byte_addr_t  accel_addr,
    input  mem_pkg::data_word_t  accel_wrt_data,
    input  logic                 accel_wrt_en,
    input  logic                 accel_rd_en,
    output logic                 accel_wrt_done,
    output logic                 accel_rd_valid,
    output mem_pkg::accel_line_t accel_rd_data,
    // core fetch
    input  mem_pkg::byte_addr_t  fetch_addr,
    output mem_pkg::instr_t      fetch_instr,
    output logic                 run
);

    localparam int IM_AW = $clog2(`IM_DEPTH);

    logic                boot_dm_wrt_en;
    logic                boot_im_wrt_en;
    mem_pkg::byte_addr_t boot_addr;
    mem_pkg::data_word_t boot_wrt_data;
    logic [IM_AW-1:0]    im_idx;

    // byte address to instruction word index
    function automatic logic [IM_AW-1:0] im_index(input mem_pkg::byte_addr_t addr);
        mem_pkg::byte_addr_t off;
        off = addr - mem_pkg::byte_addr_t'(`IM_BASE);
        return off[IM_AW+1:2];
    endfunction

    cpu_boot u_boot (
        .clk            (clk),
        .rst_n          (rst_n),
        .ready          (ready),
        .rd_valid       (rd_valid),
        .tx_done        (tx_done),
        .ex_wrt_data    (ex_wrt_data),
        .op             (op),
        .ex_addr        (ex_addr),
        .boot_dm_wrt_en (boot_dm_wrt_en),
        .boot_im_wrt_en (boot_im_wrt_en),
        .boot_addr      (boot_addr),
        .boot_wrt_data  (boot_wrt_data),
        .run            (run)
    );

    cpu_datamem u_datamem (
        .clk            (clk),
        .rst_n          (rst_n),
        .run            (run),
        .boot_wrt_en    (boot_dm_wrt_en),
        .boot_addr      (boot_addr),
        .boot_wrt_data  (boot_wrt_data),
        .accel_addr     (accel_addr),
        .accel_wrt_data (accel_wrt_data),
        .accel_wrt_en   (accel_wrt_en),
        .accel_rd_en    (accel_rd_en),
        .accel_wrt_done (accel_wrt_done),
        .accel_rd_valid (accel_rd_valid),
        .accel_rd_data  (accel_rd_data)
    );

    //////////////////////////////////////////////////////////////////////
    // instruction memory
    //////////////////////////////////////////////////////////////////////

    // boot write address wins over fetch
    assign im_idx = boot_im_wrt_en ? im_index(boot_addr) : im_index(fetch_addr);

    word_ram #(
        .payload_t (mem_pkg::instr_t),
        .DEPTH     (`IM_DEPTH)
    ) u_instrmem (
        .clk      (clk),
        .wrt_en   (boot_im_wrt_en),
        .wrt_addr (im_idx),
        .wrt_data (mem_pkg::instr_t'(boot_wrt_data)),
        .rd_en    (!boot_im_wrt_en),   // fetch holds during boot writes
        .rd_addr  (im_idx),
        .rd_data  (fetch_instr)
    );

endmodule

// File: hdl/cpu_boot.sv
// boot load sequencer
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_boot (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 ready,
    input  logic                 rd_valid,
    input  logic                 tx_done,
    input  mem_pkg::data_word_t  ex_wrt_data,
    output boot_pkg::bus_op_t    op,
    output boot_pkg::host_addr_t ex_addr,
    output logic                 boot_dm_wrt_en,
    output logic                 boot_im_wrt_en,
    output mem_pkg::byte_addr_t  boot_addr,
    output mem_pkg::data_word_t  boot_wrt_data,
    output logic                 run
);

    localparam int SEG_N = (`DM_SEGMENTS > `IM_SEGMENTS) ? `DM_SEGMENTS : `IM_SEGMENTS;
    localparam int SEG_W = $clog2(SEG_N);

    boot_pkg::boot_state_t state, state_nxt;
    logic [SEG_W-1:0]      seg_cnt;
    mem_pkg::byte_addr_t   cur_addr;
    mem_pkg::byte_addr_t   seg_base;
    logic                  in_im, in_wait, in_load;
    logic                  last_seg, seg_end, wr_word;

    //////////////////////////////////////////////////////////////////////
    // state decode and segment base
    //////////////////////////////////////////////////////////////////////

    assign in_im   = (state == boot_pkg::WAIT_IM) || (state == boot_pkg::LOAD_IM);
    assign in_wait = (state == boot_pkg::WAIT_DM) || (state == boot_pkg::WAIT_IM);
    assign in_load = (state == boot_pkg::LOAD_DM) || (state == boot_pkg::LOAD_IM);

    // regular stride replaces the old address tables
    assign seg_base = in_im ?
        mem_pkg::byte_addr_t'(`IM_BASE + seg_cnt * `SEG_STRIDE) :
        mem_pkg::byte_addr_t'(`DM_BASE + seg_cnt * `SEG_STRIDE);

    assign last_seg = in_im ? (seg_cnt == SEG_W'(`IM_SEGMENTS - 1)) :
                              (seg_cnt == SEG_W'(`DM_SEGMENTS - 1));

    // a single word segment closes in its request cycle
    assign seg_end = (in_load && tx_done) || (in_wait && rd_valid && tx_done);

    //////////////////////////////////////////////////////////////////////
    // next state
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        case (state)
            boot_pkg::BOOT_IDLE: begin
                if (ready) state_nxt = boot_pkg::WAIT_DM;
            end
            boot_pkg::WAIT_DM, boot_pkg::LOAD_DM: begin
                if (seg_end) begin
                    state_nxt = last_seg ? boot_pkg::WAIT_IM : boot_pkg::WAIT_DM;
                end else if (rd_valid) begin
                    state_nxt = boot_pkg::LOAD_DM;
                end
            end
            boot_pkg::WAIT_IM, boot_pkg::LOAD_IM: begin
                if (seg_end) begin
                    state_nxt = last_seg ? boot_pkg::RUN : boot_pkg::WAIT_IM;
                end else if (rd_valid) begin
                    state_nxt = boot_pkg::LOAD_IM;
                end
            end
            boot_pkg::RUN: state_nxt = boot_pkg::RUN;  // stays until reset
            default: state_nxt = boot_pkg::BOOT_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= boot_pkg::BOOT_IDLE;
            seg_cnt  <= '0;
            cur_addr <= '0;
        end else begin
            state <= state_nxt;
            if (seg_end) begin
                seg_cnt <= last_seg ? '0 : seg_cnt + 1'b1;  // wraps for im pass
            end
            if (in_wait && rd_valid) begin
                cur_addr <= seg_base + 16'd4;   // word 0 already at base
            end else if (in_load) begin
                cur_addr <= cur_addr + 16'd4;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // host request and memory writes
    //////////////////////////////////////////////////////////////////////

    assign op = (in_wait || in_load) ? boot_pkg::READ : boot_pkg::IDLE;

    always_comb begin
        ex_addr = '0;
        if (in_wait || in_load) begin
            ex_addr = {48'h0, seg_base};
            if (in_im) ex_addr[`IM_SPACE_BIT] = 1'b1;   // instruction space flag
        end
    end

    assign wr_word        = (in_wait && rd_valid) || in_load;
    assign boot_dm_wrt_en = wr_word && !in_im;
    assign boot_im_wrt_en = wr_word && in_im;
    assign boot_addr      = in_wait ? seg_base : cur_addr;
    assign boot_wrt_data  = ex_wrt_data;
    assign run            = (state == boot_pkg::RUN);

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // in a wait state tx_done may only come with the lone word
    a_done_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n) (in_wait && tx_done) |-> rd_valid
    ) else $error("tx_done seen while waiting for a segment");

    a_seg_len: assert property (
        @(posedge clk) disable iff (!rst_n)
            in_load |-> (int'(cur_addr - seg_base) < `SEG_MAX_WORDS * 4)
    ) else $error("segment longer than %0d words", `SEG_MAX_WORDS);

endmodule

// File: hdl/cpu_datamem.sv
// banked data memory
`timescale 1ns/1ps
`include "cpu_settings.svh"

module cpu_datamem (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 run,
    // boot loader
    input  logic                 boot_wrt_en,
    input  mem_pkg::byte_addr_t  boot_addr,
    input  mem_pkg::data_word_t  boot_wrt_data,
    // accelerator
    input  mem_pkg::byte_addr_t  accel_addr,
    input  mem_pkg::data_word_t  accel_wrt_data,
    input  logic                 accel_wrt_en,
    input  logic                 accel_rd_en,
    output logic                 accel_wrt_done,
    output logic                 accel_rd_valid,
    output mem_pkg::accel_line_t accel_rd_data
);

    localparam int BANK_W = $clog2(`LINE_WORDS);
    localparam int ROW_W  = $clog2(`DM_ROWS);
    localparam int ROW_LO = BANK_W + 2;

    logic                wr_en;
    mem_pkg::data_word_t wr_data;
    mem_pkg::byte_addr_t wr_off;
    logic [BANK_W-1:0]   wr_bank;
    logic [ROW_W-1:0]    wr_row;
    logic                rd_req;
    mem_pkg::byte_addr_t rd_off;
    logic [ROW_W-1:0]    rd_row;
    mem_pkg::data_word_t bank_rd [`LINE_WORDS];

    //////////////////////////////////////////////////////////////////////
    // address split and port select
    //////////////////////////////////////////////////////////////////////

    // boot owns the write port until run and the accelerator after
    assign wr_en   = run ? accel_wrt_en : boot_wrt_en;
    assign wr_data = run ? accel_wrt_data : boot_wrt_data;
    assign wr_off  = (run ? accel_addr : boot_addr) - mem_pkg::byte_addr_t'(`DM_BASE);
    assign wr_bank = wr_off[BANK_W+1:2];          // word within line
    assign wr_row  = wr_off[ROW_LO+ROW_W-1:ROW_LO];

    assign rd_req  = run && accel_rd_en;
    assign rd_off  = accel_addr - mem_pkg::byte_addr_t'(`DM_BASE);
    assign rd_row  = rd_off[ROW_LO+ROW_W-1:ROW_LO]; // low bits dropped for a whole line

    //////////////////////////////////////////////////////////////////////
    // banks
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < `LINE_WORDS; i++) begin : g_bank
        word_ram #(
            .payload_t (mem_pkg::data_word_t),
            .DEPTH     (`DM_ROWS)
        ) u_bank (
            .clk      (clk),
            .wrt_en   (wr_en && (wr_bank == BANK_W'(i))),
            .wrt_addr (wr_row),
            .wrt_data (wr_data),
            .rd_en    (rd_req),
            .rd_addr  (rd_row),
            .rd_data  (bank_rd[i])
        );
    end

    // bank i lands in word i of the line
    always_comb begin
        for (int i = 0; i < `LINE_WORDS; i++) begin
            accel_rd_data[i] = bank_rd[i];
        end
    end

    // done and valid follow the request by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            accel_wrt_done <= 1'b0;
            accel_rd_valid <= 1'b0;
        end else begin
            accel_wrt_done <= run && accel_wrt_en;
            accel_rd_valid <= rd_req;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // boot sequencer must be finished before run
    a_no_boot_in_run: assert property (
        @(posedge clk) disable iff (!rst_n) boot_wrt_en |-> !run
    ) else $error("boot write while run is high");

endmodule

// File: hdl/cpu_settings.svh
// cpu boot and memory settings
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

//////////////////////////////////////////////////////////////////////
// segment tables
//////////////////////////////////////////////////////////////////////

`define DM_SEGMENTS   4        // data segments fetched at boot
`define IM_SEGMENTS   4        // instruction segments, fetched after data
`define SEG_STRIDE    'h40     // bytes between segment bases
`define SEG_MAX_WORDS 16

//////////////////////////////////////////////////////////////////////
// address map
//////////////////////////////////////////////////////////////////////

`define DM_BASE       'h1000   // byte address of data segment 0
`define IM_BASE       'h0000
`define IM_SPACE_BIT  16       // ex_addr bit flagging instruction space

//////////////////////////////////////////////////////////////////////
// memory geometry
//////////////////////////////////////////////////////////////////////

// one bank per word of an accelerator line
`define LINE_WORDS    16
`define DM_ROWS       256      // rows in each data bank
`define IM_DEPTH      256      // instruction words

`endif

// File: hdl/mem_pkg.sv
// memory side types
`include "cpu_settings.svh"

package mem_pkg;

    // data memory word
    typedef logic [31:0] data_word_t;

    // one instruction, same width as a data word
    typedef logic [31:0] instr_t;

    // internal byte address, wide enough for both memories
    typedef logic [15:0] byte_addr_t;

    // accelerator line, word 0 sits in bits 31:0
    typedef logic [`LINE_WORDS-1:0][31:0] accel_line_t;

endpackage

// File: hdl/word_ram.sv
// synchronous word ram
`timescale 1ns/1ps

module word_ram #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 256
) (
    input  logic                     clk,
    input  logic                     wrt_en,
    input  logic [$clog2(DEPTH)-1:0] wrt_addr,
    input  payload_t                 wrt_data,
    input  logic                     rd_en,
    input  logic [$clog2(DEPTH)-1:0] rd_addr,
    output payload_t                 rd_data
);

    payload_t mem [DEPTH];

    // write and registered read share the edge, read sees old data
    always_ff @(posedge clk) begin
        if (wrt_en) begin
            mem[wrt_addr] <= wrt_data;
        end
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    // callers compute the index from byte addresses
    a_wrt_in_range: assert property (
        @(posedge clk) wrt_en |-> (int'(wrt_addr) < DEPTH)
    ) else $error("word_ram write index %0d out of range", wrt_addr);

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the cpu testbench with verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f build.f --top-module tb_cpu \
    -Mdir "$OBJ" -o tb_cpu
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$OBJ/tb_cpu" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi

if ! grep -q "Test OK" "$LOG"; then
    echo "no result line found in $LOG"
    exit 1
fi

exit 0

// File: testbench/tb_cpu.sv
// cpu boot and memory testbench
`timescale 1ns/1ps
`include "cpu_settings.svh"

module tb_cpu;

    typedef enum logic [1:0] {ROW_SEG, ROW_WRT, ROW_RD, ROW_FETCH} row_kind_t;

    typedef struct packed {
        row_kind_t   kind;
        logic        im;      // segment in instruction space
        logic [3:0]  seg;
        logic [4:0]  cnt;     // words sent or fetched
        logic [15:0] addr;
        logic [31:0] data;
    } row_t;

    localparam int N_ROWS = 20;

    logic                 clk;
    logic                 rst_n;
    logic                 ready;
    logic                 rd_valid;
    logic                 tx_done;
    mem_pkg::data_word_t  ex_wrt_data;
    boot_pkg::bus_op_t    op;
    boot_pkg::host_addr_t ex_addr;
    mem_pkg::byte_addr_t  accel_addr;
    mem_pkg::data_word_t  accel_wrt_data;
    logic                 accel_wrt_en;
    logic                 accel_rd_en;
    logic                 accel_wrt_done;
    logic                 accel_rd_valid;
    mem_pkg::accel_line_t accel_rd_data;
    mem_pkg::byte_addr_t  fetch_addr;
    mem_pkg::instr_t      fetch_instr;
    logic                 run;

    logic [31:0] dm_exp [`DM_SEGMENTS][`SEG_MAX_WORDS];   // image the host sent
    logic [31:0] im_exp [`IM_SEGMENTS][`SEG_MAX_WORDS];
    int          errors;
    int          timeouts;
    bit          boot_done;
    bit          aborted;

    //////////////////////////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////////////////////////

    row_t rows [N_ROWS] = '{
        '{ROW_SEG,   1'b0, 4'd0, 5'd16, 16'h0000, 32'h0},
        '{ROW_WRT,   1'b0, 4'd0, 5'd0,  16'h100c, 32'hdeadbeef},  // ignored while still booting
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h1000, 32'h0},
        '{ROW_SEG,   1'b0, 4'd1, 5'd16, 16'h0000, 32'h0},
        '{ROW_SEG,   1'b0, 4'd2, 5'd16, 16'h0000, 32'h0},
        '{ROW_SEG,   1'b0, 4'd3, 5'd16, 16'h0000, 32'h0},
        '{ROW_SEG,   1'b1, 4'd0, 5'd1,  16'h0000, 32'h0},
        '{ROW_SEG,   1'b1, 4'd1, 5'd5,  16'h0000, 32'h0},
        '{ROW_SEG,   1'b1, 4'd2, 5'd16, 16'h0000, 32'h0},
        '{ROW_SEG,   1'b1, 4'd3, 5'd2,  16'h0000, 32'h0},
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h1000, 32'h0},
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h1040, 32'h0},
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h1080, 32'h0},
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h10c0, 32'h0},
        '{ROW_WRT,   1'b0, 4'd0, 5'd0,  16'h109c, 32'h5a5a1234},  // seg 2 word 7
        '{ROW_RD,    1'b0, 4'd0, 5'd0,  16'h10a4, 32'h0},         // low bits ignored
        '{ROW_FETCH, 1'b0, 4'd0, 5'd1,  16'h0000, 32'h0},
        '{ROW_FETCH, 1'b0, 4'd0, 5'd5,  16'h0040, 32'h0},
        '{ROW_FETCH, 1'b0, 4'd0, 5'd16, 16'h0080, 32'h0},
        '{ROW_FETCH, 1'b0, 4'd0, 5'd2,  16'h00c0, 32'h0}
    };

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    cpu cpu_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ready          (ready),
        .rd_valid       (rd_valid),
        .tx_done        (tx_done),
        .ex_wrt_data    (ex_wrt_data),
        .op             (op),
        .ex_addr        (ex_addr),
        .accel_addr     (accel_addr),
        .accel_wrt_data (accel_wrt_data),
        .accel_wrt_en   (accel_wrt_en),
        .accel_rd_en    (accel_rd_en),
        .accel_wrt_done (accel_wrt_done),
        .accel_rd_valid (accel_rd_valid),
        .accel_rd_data  (accel_rd_data),
        .fetch_addr     (fetch_addr),
        .fetch_instr    (fetch_instr),
        .run            (run)
    );

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        errors++;
        $display("[FAIL] %0t %s got %0h expected %0h", $time, name, got, exp);
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("timeout while waiting for %s", what);
    endtask

    //////////////////////////////////////////////////////////////////////
    // host model
    //////////////////////////////////////////////////////////////////////

    task automatic serve_segment(input logic im, input int k, input int n);
        boot_pkg::host_addr_t base;
        logic [31:0]          w;
        int                   idle;
        int                   tmo;
        bit                   last;
        base = 64'(`SEG_STRIDE) * 64'(k);
        if (im) begin
            base = (base + 64'(`IM_BASE)) | (64'd1 << `IM_SPACE_BIT);
        end else begin
            base = base + 64'(`DM_BASE);
        end
        tmo = 0;
        @(negedge clk);
        while (op !== boot_pkg::READ && tmo < 100) begin
            @(negedge clk);
            tmo++;
        end
        if (op !== boot_pkg::READ) begin
            report_timeout("a READ request from the boot FSM");
            return;
        end
        if (ex_addr !== base) report_mismatch("ex_addr", ex_addr, base);
        idle = $urandom_range(5, 0);
        repeat (idle) @(negedge clk);                // host latency
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            w = $urandom;
            rd_valid    <= (i == 0);
            tx_done     <= (i == n - 1);
            ex_wrt_data <= w;
            if (im) begin
                im_exp[k][i] = w;
            end else begin
                dm_exp[k][i] = w;
            end
            @(negedge clk);
            if (op !== boot_pkg::READ) report_mismatch("op", 64'(op), 64'(boot_pkg::READ));
            if (run !== 1'b0) report_mismatch("run", 64'(run), 64'd0);
        end
        @(posedge clk);
        rd_valid <= 1'b0;
        tx_done  <= 1'b0;
        @(negedge clk);
        last = im && (k == `IM_SEGMENTS - 1);
        if (run !== last) report_mismatch("run", 64'(run), 64'(last));
        if (last && op !== boot_pkg::IDLE) begin
            report_mismatch("op", 64'(op), 64'(boot_pkg::IDLE));
        end
        boot_done = boot_done || last;
    endtask

    //////////////////////////////////////////////////////////////////////
    // accelerator and fetch ports
    //////////////////////////////////////////////////////////////////////

    task automatic accel_write(input logic [15:0] addr, input logic [31:0] data);
        int off;
        off = int'(addr) - `DM_BASE;
        @(posedge clk);
        accel_addr     <= addr;
        accel_wrt_data <= data;
        accel_wrt_en   <= 1'b1;
        @(posedge clk);
        accel_wrt_en <= 1'b0;
        @(negedge clk);
        if (accel_wrt_done !== boot_done) begin
            report_mismatch("accel_wrt_done", 64'(accel_wrt_done), 64'(boot_done));
        end
        if (boot_done) dm_exp[off / `SEG_STRIDE][(off % `SEG_STRIDE) / 4] = data;
        @(negedge clk);
        if (accel_wrt_done !== 1'b0) begin
            report_mismatch("accel_wrt_done", 64'(accel_wrt_done), 64'd0);
        end
    endtask

    task automatic accel_read(input logic [15:0] addr);
        int seg;
        seg = (int'(addr) - `DM_BASE) / `SEG_STRIDE;
        @(posedge clk);
        accel_addr  <= addr;
        accel_rd_en <= 1'b1;
        @(posedge clk);
        accel_rd_en <= 1'b0;
        @(negedge clk);
        if (accel_rd_valid !== boot_done) begin
            report_mismatch("accel_rd_valid", 64'(accel_rd_valid), 64'(boot_done));
        end
        if (boot_done) begin
            for (int i = 0; i < `LINE_WORDS; i++) begin
                if (accel_rd_data[i] !== dm_exp[seg][i]) begin
                    report_mismatch($sformatf("accel_rd_data[%0d]", i),
                                    64'(accel_rd_data[i]), 64'(dm_exp[seg][i]));
                end
            end
        end
        @(negedge clk);
        if (accel_rd_valid !== 1'b0) begin
            report_mismatch("accel_rd_valid", 64'(accel_rd_valid), 64'd0);
        end
    endtask

    task automatic fetch_words(input logic [15:0] addr, input int n);
        int seg;
        seg = (int'(addr) - `IM_BASE) / `SEG_STRIDE;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            fetch_addr <= addr + 16'(4 * i);
            @(posedge clk);
            @(negedge clk);
            if (fetch_instr !== im_exp[seg][i]) begin
                report_mismatch("fetch_instr", 64'(fetch_instr), 64'(im_exp[seg][i]));
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(32'hd52c));
        rst_n          = 1'b0;
        ready          = 1'b0;
        rd_valid       = 1'b0;
        tx_done        = 1'b0;
        ex_wrt_data    = '0;
        accel_addr     = '0;
        accel_wrt_data = '0;
        accel_wrt_en   = 1'b0;
        accel_rd_en    = 1'b0;
        fetch_addr     = '0;
        errors         = 0;
        timeouts       = 0;
        boot_done      = 1'b0;
        aborted        = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // bus stays quiet until the host is ready
        repeat (4) begin
            @(negedge clk);
            if (op !== boot_pkg::IDLE) report_mismatch("op", 64'(op), 64'(boot_pkg::IDLE));
            if (ex_addr !== '0) report_mismatch("ex_addr", ex_addr, 64'd0);
            if (run !== 1'b0) report_mismatch("run", 64'(run), 64'd0);
        end
        @(posedge clk);
        ready <= 1'b1;
        for (int r = 0; r < N_ROWS && !aborted; r++) begin
            case (rows[r].kind)
                ROW_SEG: serve_segment(rows[r].im, int'(rows[r].seg), int'(rows[r].cnt));
                ROW_WRT: accel_write(rows[r].addr, rows[r].data);
                ROW_RD:  accel_read(rows[r].addr);
                default: fetch_words(rows[r].addr, int'(rows[r].cnt));
            endcase
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
